// File: Makefile
# Verilator build and run of the analog path testbench
VERILATOR ?= verilator
TOP       ?= tb_rp_analog_top
FLIST     ?= rp_analog_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= === PASS ===

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

// File: adc_frontend.sv
// adc input stage with two register stages from pins to sample
// pin bits 1:0 are ignored (16-bit footprint, 14-bit converter)
// loopback samples pass only the output register
`include "rp_defs.svh"

module adc_frontend (
  input  logic             adc_clk,
  input  logic             rst_n_i,
  input  rp_pkg::adc_raw_t adc_dat_a_i,  // ch A pins
  input  rp_pkg::adc_raw_t adc_dat_b_i,  // ch B pins
  input  logic             loop_en_i,    // digital loopback
  input  rp_pkg::smp_t     loop_a_i,     // from dac side
  input  rp_pkg::smp_t     loop_b_i,
  output rp_pkg::smp_t     smp_a_o,
  output rp_pkg::smp_t     smp_b_o
);
  import rp_pkg::*;

  logic [`RP_SMP_W-1:0] pin_a_q, pin_b_q; // io block regs
  smp_t                 conv_a, conv_b;

  // io pin register on raw data
  always_ff @(posedge adc_clk)
  begin
    pin_a_q <= adc_dat_a_i[`RP_ADC_PIN_W-1 -: `RP_SMP_W];
    pin_b_q <= adc_dat_b_i[`RP_ADC_PIN_W-1 -: `RP_SMP_W];
  end

  // neg slope to two's complement
  // sign stays and magnitude bits flip
  assign conv_a = {pin_a_q[`RP_SMP_W-1], ~pin_a_q[`RP_SMP_W-2:0]};
  assign conv_b = {pin_b_q[`RP_SMP_W-1], ~pin_b_q[`RP_SMP_W-2:0]};

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      smp_a_o <= '0;
      smp_b_o <= '0;
    end
    else
    begin
      smp_a_o <= loop_en_i ? loop_a_i : conv_a; // loopback overrides pins
      smp_b_o <= loop_en_i ? loop_b_i : conv_b;
    end
  end

endmodule

// File: dac_backend.sv
// dac output stage, one register from level to pin code
// pins idle at midscale 0x1FFF while in reset
`include "rp_defs.svh"

module dac_backend (
  input  logic              adc_clk,
  input  logic              rst_n_i,
  input  rp_pkg::smp_t      level_a_i,  // two's complement level
  input  rp_pkg::smp_t      level_b_i,
  output rp_pkg::dac_code_t dac_a_o,    // neg-slope pin code
  output rp_pkg::dac_code_t dac_b_o,
  output rp_pkg::smp_t      smp_a_o,    // loopback copy
  output rp_pkg::smp_t      smp_b_o
);
  import rp_pkg::*;

  dac_code_t code_a, code_b;

  // two's complement to neg slope, same bit trick as on adc side
  assign code_a = {level_a_i[`RP_SMP_W-1], ~level_a_i[`RP_SMP_W-2:0]};
  assign code_b = {level_b_i[`RP_SMP_W-1], ~level_b_i[`RP_SMP_W-2:0]};

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      dac_a_o <= {1'b0, {(`RP_SMP_W-1){1'b1}}}; // level 0
      dac_b_o <= {1'b0, {(`RP_SMP_W-1){1'b1}}};
      smp_a_o <= '0;
      smp_b_o <= '0;
    end
    else
    begin
      dac_a_o <= code_a;
      dac_b_o <= code_b;
      smp_a_o <= level_a_i; // aligned with pin code
      smp_b_o <= level_b_i;
    end
  end

endmodule

// File: hk_regs.sv
// housekeeping slave, region 0
// only addr bits below the region field are decoded
// unknown offsets read zero, writes to them are dropped
`include "rp_defs.svh"

module hk_regs (
  input  logic              adc_clk,
  input  logic              rst_n_i,
  input  rp_pkg::bus_addr_t sys_addr_i,
  input  rp_pkg::bus_data_t sys_wdata_i,
  input  logic              sys_wen_i,
  input  logic              sys_ren_i,
  output rp_pkg::bus_data_t sys_rdata_o,
  output logic              sys_ack_o,
  output rp_pkg::led_t      led_o,
  output logic              loop_en_o,
  output rp_pkg::smp_t      dac_level_a_o,
  output rp_pkg::smp_t      dac_level_b_o
);
  import rp_pkg::*;

  logic [`RP_REGION_LSB-1:0] off; // offset in region

  assign off = sys_addr_i[`RP_REGION_LSB-1:0];

  // control regs and ack
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      sys_ack_o     <= 1'b0;
      led_o         <= '0;
      loop_en_o     <= 1'b0;
      dac_level_a_o <= '0;
      dac_level_b_o <= '0;
    end
    else
    begin
      sys_ack_o <= sys_wen_i | sys_ren_i; // single cycle answer
      if (sys_wen_i)
      begin
        case (off)
          `RP_HK_ADDR_LOOP:  loop_en_o     <= sys_wdata_i[0];
          `RP_HK_ADDR_LED:   led_o         <= led_t'(sys_wdata_i);
          `RP_HK_ADDR_DAC_A: dac_level_a_o <= smp_t'(sys_wdata_i[`RP_SMP_W-1:0]);
          `RP_HK_ADDR_DAC_B: dac_level_b_o <= smp_t'(sys_wdata_i[`RP_SMP_W-1:0]);
          default:           ; // id is read-only
        endcase
      end
    end
  end

  // read data, valid with ack
  always_ff @(posedge adc_clk)
  begin
    if (sys_ren_i)
    begin
      case (off)
        `RP_HK_ADDR_ID:    sys_rdata_o <= `RP_HK_ID;
        `RP_HK_ADDR_LOOP:  sys_rdata_o <= bus_data_t'(loop_en_o);
        `RP_HK_ADDR_LED:   sys_rdata_o <= bus_data_t'(led_o);
        `RP_HK_ADDR_DAC_A: sys_rdata_o <= bus_data_t'(dac_level_a_o); // sign-extended
        `RP_HK_ADDR_DAC_B: sys_rdata_o <= bus_data_t'(dac_level_b_o);
        default:           sys_rdata_o <= '0;
      endcase
    end
  end

endmodule

// File: rp_analog_top.f
+incdir+.
rp_pkg.sv
adc_frontend.sv
dac_backend.sv
hk_regs.sv
scope_buffer.sv
sys_bus_decoder.sv
rp_analog_top.sv
tb_rp_analog_top.sv

// File: rp_analog_top.sv
// analog data path top, everything on adc_clk
// dac levels come from housekeeping registers, no dsp in between
// adc ch B only reaches the dac side through loopback
`include "rp_defs.svh"

module rp_analog_top (
  input  logic              adc_clk,
  input  logic              rst_n_i,
  input  rp_pkg::adc_raw_t  adc_dat_a_i,
  input  rp_pkg::adc_raw_t  adc_dat_b_i,
  output rp_pkg::dac_code_t dac_dat_a_o,
  output rp_pkg::dac_code_t dac_dat_b_o,
  output rp_pkg::led_t      led_o,
  input  rp_pkg::bus_addr_t sys_addr_i,
  input  rp_pkg::bus_data_t sys_wdata_i,
  input  logic              sys_wen_i,
  input  logic              sys_ren_i,
  output rp_pkg::bus_data_t sys_rdata_o,
  output logic              sys_ack_o,
  output logic              sys_err_o
);
  import rp_pkg::*;

  smp_t                       adc_smp_a;              // to scope
  smp_t                       dac_smp_a, dac_smp_b;   // loopback return
  smp_t                       lvl_a, lvl_b;           // hk dac levels
  logic                       loop_en;
  logic [`RP_NUM_REGIONS-1:0] sys_wen, sys_ren;
  bus_data_t                  hk_rdata, sc_rdata;
  logic                       hk_ack, sc_ack;

  ////////////////////////////////////////
  // analog path
  ////////////////////////////////////////

  adc_frontend i_adc (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .loop_en_i   (loop_en),
    .loop_a_i    (dac_smp_a),
    .loop_b_i    (dac_smp_b),
    .smp_a_o     (adc_smp_a),
    .smp_b_o     ()                                   // no ch B consumer
  );

  dac_backend i_dac (
    .adc_clk   (adc_clk),
    .rst_n_i   (rst_n_i),
    .level_a_i (lvl_a),
    .level_b_i (lvl_b),
    .dac_a_o   (dac_dat_a_o),
    .dac_b_o   (dac_dat_b_o),
    .smp_a_o   (dac_smp_a),
    .smp_b_o   (dac_smp_b)
  );

  ////////////////////////////////////////
  // system bus
  ////////////////////////////////////////

  sys_bus_decoder i_dec (
    .adc_clk (adc_clk),        .rst_n_i     (rst_n_i),
    .sys_addr_i (sys_addr_i),  .sys_wen_i   (sys_wen_i),  .sys_ren_i (sys_ren_i),
    .sys_wen_o  (sys_wen),     .sys_ren_o   (sys_ren),
    .hk_rdata_i (hk_rdata),    .hk_ack_i    (hk_ack),
    .sc_rdata_i (sc_rdata),    .sc_ack_i    (sc_ack),
    .sys_rdata_o (sys_rdata_o), .sys_ack_o  (sys_ack_o),  .sys_err_o (sys_err_o)
  );

  hk_regs i_hk (                                      // region 0
    .adc_clk (adc_clk),        .rst_n_i     (rst_n_i),
    .sys_addr_i (sys_addr_i),  .sys_wdata_i (sys_wdata_i),
    .sys_wen_i  (sys_wen[0]),  .sys_ren_i   (sys_ren[0]),
    .sys_rdata_o (hk_rdata),   .sys_ack_o   (hk_ack),
    .led_o      (led_o),       .loop_en_o   (loop_en),
    .dac_level_a_o (lvl_a),    .dac_level_b_o (lvl_b)
  );

  scope_buffer i_scope (                              // region 1
    .adc_clk (adc_clk),        .rst_n_i     (rst_n_i),
    .smp_i      (adc_smp_a),
    .sys_addr_i (sys_addr_i),  .sys_wdata_i (sys_wdata_i),
    .sys_wen_i  (sys_wen[1]),  .sys_ren_i   (sys_ren[1]),
    .sys_rdata_o (sc_rdata),   .sys_ack_o   (sc_ack)
  );

endmodule

// File: rp_defs.svh
// widths, region map and register offsets shared by RTL and testbench
// offsets are byte addresses inside one 1 MB region, 32-bit word aligned
// buffer depth must stay a power of two (pointer wraps by overflow)
`ifndef RP_DEFS_SVH
`define RP_DEFS_SVH

`define RP_ADC_PIN_W     16            // adc pins, lower 2 bits unused
`define RP_SMP_W         14            // converter sample width
`define RP_BUS_W         32            // sys bus addr/data width
`define RP_REGION_LSB    20            // region field position
`define RP_REGION_W      3
`define RP_NUM_REGIONS   8
`define RP_HK_ID         32'h5250_0A01 // read-only board id

// housekeeping offsets (region 0)
`define RP_HK_ADDR_ID    20'h00000
`define RP_HK_ADDR_LOOP  20'h00004
`define RP_HK_ADDR_LED   20'h00008
`define RP_HK_ADDR_DAC_A 20'h0000C
`define RP_HK_ADDR_DAC_B 20'h00010

// scope offsets (region 1)
`define RP_SC_ADDR_CTRL    20'h00000
`define RP_SC_ADDR_THRESH  20'h00004
`define RP_SC_ADDR_TRIGPTR 20'h00008
`define RP_SC_ADDR_BUF     20'h00100 // ring window, one word per entry

`define RP_BUF_DEPTH     16
`define RP_BUF_AW        4
`define RP_POST_TRIG     8             // samples kept after trigger, trigger included
`define RP_LED_W         8

`endif

// File: rp_pkg.sv
// shared types of the analog path and the system bus
// samples are two's complement, converter codes are negative slope
`include "rp_defs.svh"

package rp_pkg;

  ////////////////////////////////////////
  // analog data
  ////////////////////////////////////////

  typedef logic signed [`RP_SMP_W-1:0]     smp_t;      // two's complement sample
  typedef logic        [`RP_ADC_PIN_W-1:0] adc_raw_t;  // raw adc pin word
  typedef logic        [`RP_SMP_W-1:0]     dac_code_t; // neg-slope dac code

  ////////////////////////////////////////
  // system bus
  ////////////////////////////////////////

  typedef logic [`RP_BUS_W-1:0]    bus_addr_t;
  typedef logic [`RP_BUS_W-1:0]    bus_data_t;
  typedef logic [`RP_REGION_W-1:0] region_t;   // addr bits 22:20

  // misc
  typedef logic [`RP_LED_W-1:0]  led_t;
  typedef logic [`RP_BUF_AW-1:0] buf_ptr_t;    // ring pointer, wraps freely

endpackage

// File: scope_buffer.sv
// single channel scope on a small ring buffer, region 1
// trigger on rising crossing of THRESH, signed compare
// the ring keeps overwriting until the trigger, so pre-trigger history
// is at most RP_BUF_DEPTH - RP_POST_TRIG samples
`include "rp_defs.svh"

module scope_buffer (
  input  logic              adc_clk,
  input  logic              rst_n_i,
  input  rp_pkg::smp_t      smp_i,
  input  rp_pkg::bus_addr_t sys_addr_i,
  input  rp_pkg::bus_data_t sys_wdata_i,
  input  logic              sys_wen_i,
  input  logic              sys_ren_i,
  output rp_pkg::bus_data_t sys_rdata_o,
  output logic              sys_ack_o
);
  import rp_pkg::*;

  localparam int OFF_W = `RP_REGION_LSB;
  localparam int WIN_LSB = 2 + `RP_BUF_AW;               // above entry index
  localparam int CNT_W = $clog2(`RP_POST_TRIG + 1);

  smp_t             mem [`RP_BUF_DEPTH];                 // sample ring
  logic [OFF_W-1:0] off;
  logic             buf_hit;                             // addr in ring window
  buf_ptr_t         rd_idx, wr_ptr, trig_ptr;
  smp_t             thresh;
  logic             armed, done, trig_seen, prev_below;
  logic             arm_req, trig_fire, last_wr;
  logic [CNT_W-1:0] post_cnt, post_nxt;                  // samples since trigger

  ////////////////////////////////////////
  // decode and trigger
  ////////////////////////////////////////

  assign off     = sys_addr_i[OFF_W-1:0];
  assign rd_idx  = off[2 +: `RP_BUF_AW];
  assign buf_hit = (off >> WIN_LSB) == (`RP_SC_ADDR_BUF >> WIN_LSB);
  assign arm_req = sys_wen_i && (off == `RP_SC_ADDR_CTRL) && sys_wdata_i[0];

  // first crossing from below only
  assign trig_fire = armed && !trig_seen && prev_below && (smp_i >= thresh);
  assign post_nxt  = trig_fire ? CNT_W'(1) : post_cnt + 1'b1;
  assign last_wr   = armed && (trig_fire || trig_seen) &&
                     (post_nxt == CNT_W'(`RP_POST_TRIG));

  ////////////////////////////////////////
  // capture control
  ////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      sys_ack_o  <= 1'b0;
      thresh     <= '0;
      armed      <= 1'b0;
      done       <= 1'b0;
      trig_seen  <= 1'b0;
      prev_below <= 1'b0;
      wr_ptr     <= '0;
      trig_ptr   <= '0;
      post_cnt   <= '0;
    end
    else
    begin
      sys_ack_o  <= sys_wen_i | sys_ren_i;
      prev_below <= (smp_i < thresh);                    // tracked even when idle
      if (sys_wen_i && (off == `RP_SC_ADDR_THRESH))
        thresh <= smp_t'(sys_wdata_i[`RP_SMP_W-1:0]);
      if (arm_req)
      begin
        armed     <= 1'b1;
        done      <= 1'b0;
        trig_seen <= 1'b0;
        wr_ptr    <= '0;
        post_cnt  <= '0;
      end
      else if (armed)
      begin
        wr_ptr <= wr_ptr + 1'b1;                         // wraps at depth
        if (trig_fire)
        begin
          trig_seen <= 1'b1;
          trig_ptr  <= wr_ptr;                           // slot of trigger sample
        end
        if (trig_fire || trig_seen)
          post_cnt <= post_nxt;
        if (last_wr)
        begin
          armed <= 1'b0;                                 // freeze ring
          done  <= 1'b1;
        end
      end
    end
  end

  // ring write
  always_ff @(posedge adc_clk)
  begin
    if (armed)
      mem[wr_ptr] <= smp_i;
  end

  // bus read, entries sign-extended
  always_ff @(posedge adc_clk)
  begin
    if (sys_ren_i)
    begin
      if (buf_hit)
        sys_rdata_o <= bus_data_t'(mem[rd_idx]);
      else
      begin
        case (off)
          `RP_SC_ADDR_CTRL:    sys_rdata_o <= bus_data_t'({done, armed});
          `RP_SC_ADDR_THRESH:  sys_rdata_o <= bus_data_t'(thresh);
          `RP_SC_ADDR_TRIGPTR: sys_rdata_o <= bus_data_t'(trig_ptr);
          default:             sys_rdata_o <= '0;
        endcase
      end
    end
  end

endmodule

// File: sys_bus_decoder.sv
// system bus splitter, 8 regions by addr bits 22:20
// region 0 housekeeping, region 1 scope, 2 to 7 answer err with zero data
// response is picked by the region latched at the last strobe
`include "rp_defs.svh"

module sys_bus_decoder (
  input  logic                       adc_clk,
  input  logic                       rst_n_i,
  input  rp_pkg::bus_addr_t          sys_addr_i,
  input  logic                       sys_wen_i,
  input  logic                       sys_ren_i,
  output logic [`RP_NUM_REGIONS-1:0] sys_wen_o,   // per region strobes
  output logic [`RP_NUM_REGIONS-1:0] sys_ren_o,
  input  rp_pkg::bus_data_t          hk_rdata_i,
  input  logic                       hk_ack_i,
  input  rp_pkg::bus_data_t          sc_rdata_i,
  input  logic                       sc_ack_i,
  output rp_pkg::bus_data_t          sys_rdata_o,
  output logic                       sys_ack_o,
  output logic                       sys_err_o
);
  import rp_pkg::*;

  localparam int      NR        = `RP_NUM_REGIONS;
  localparam int      UNUSED_LO = 2;                // first region without slave
  localparam region_t RGN_HK    = region_t'(0);
  localparam region_t RGN_SC    = region_t'(1);

  region_t         rgn, rgn_q;
  logic [NR-1:0]   cs;                              // one-hot region select
  logic            nu_ack;                          // answer for empty regions

  assign rgn = sys_addr_i[`RP_REGION_LSB +: `RP_REGION_W];

  always_comb
  begin
    cs      = '0;
    cs[rgn] = 1'b1;
  end

  assign sys_wen_o = cs & {NR{sys_wen_i}};
  assign sys_ren_o = cs & {NR{sys_ren_i}};

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      rgn_q  <= RGN_HK;
      nu_ack <= 1'b0;
    end
    else
    begin
      if (sys_wen_i || sys_ren_i)
        rgn_q <= rgn;                               // held until next strobe
      nu_ack <= |(sys_wen_o[NR-1:UNUSED_LO] | sys_ren_o[NR-1:UNUSED_LO]);
    end
  end

  // response mux
  always_comb
  begin
    case (rgn_q)
      RGN_HK:
      begin
        sys_rdata_o = hk_rdata_i;
        sys_ack_o   = hk_ack_i;
        sys_err_o   = 1'b0;
      end
      RGN_SC:
      begin
        sys_rdata_o = sc_rdata_i;
        sys_ack_o   = sc_ack_i;
        sys_err_o   = 1'b0;
      end
      default:
      begin
        sys_rdata_o = '0;
        sys_ack_o   = nu_ack;
        sys_err_o   = nu_ack;                       // err only with ack
      end
    endcase
  end

endmodule

// File: tb_rp_analog_top.sv
// directed testbench for the analog path top level
// bus master holds addr/wdata and pulses one strobe
// dut outputs are sampled at negedge
// scope tests assume threshold crossings within 40 polls of CTRL
`include "rp_defs.svh"

module tb_rp_analog_top;
  import rp_pkg::*;

  localparam int        ACK_LIMIT   = 4;
  localparam int        POLL_LIMIT  = 40;
  localparam int        TIMEOUT_CYC = 2000;                        // covers every ack and poll limit
  localparam dac_code_t MAG_MASK    = 14'h1FFF;                    // magnitude bits
  localparam bus_addr_t HK_BASE     = bus_addr_t'(0) << `RP_REGION_LSB;
  localparam bus_addr_t SC_BASE     = bus_addr_t'(1) << `RP_REGION_LSB;
  localparam bus_addr_t NU_BASE     = bus_addr_t'(5) << `RP_REGION_LSB; // no slave

  logic      adc_clk, rst_n_i;
  adc_raw_t  adc_dat_a_i, adc_dat_b_i;
  dac_code_t dac_dat_a_o, dac_dat_b_o;
  led_t      led_o;
  bus_addr_t sys_addr_i;
  bus_data_t sys_wdata_i, sys_rdata_o;
  logic      sys_wen_i, sys_ren_i, sys_ack_o, sys_err_o;
  int        errors, cycles, tests_run, tests_failed;
  led_t      led_exp;                                              // last led value written

  rp_analog_top UUT (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o),
    .led_o       (led_o),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o),
    .sys_err_o   (sys_err_o)
  );

  initial
  begin
    adc_clk = 1'b0;
    forever #20 adc_clk = ~adc_clk;
  end

  ////////////////////////////////////////
  // reference model and addresses
  ////////////////////////////////////////

  // neg slope code keeps the sign and flips the magnitude (self-inverse)
  function automatic dac_code_t to_code(input smp_t s);
    return dac_code_t'(s) ^ MAG_MASK;
  endfunction

  function automatic adc_raw_t to_pin(input smp_t s);
    return {to_code(s), 2'b10};      // junk in the two unused lsbs
  endfunction

  function automatic bus_data_t sext(input smp_t s);
    return {{(`RP_BUS_W-`RP_SMP_W){s[`RP_SMP_W-1]}}, s};
  endfunction

  function automatic bus_addr_t hk_addr(input logic [`RP_REGION_LSB-1:0] off);
    return HK_BASE | bus_addr_t'(off);
  endfunction

  function automatic bus_addr_t sc_addr(input logic [`RP_REGION_LSB-1:0] off);
    return SC_BASE | bus_addr_t'(off);
  endfunction

  function automatic bus_addr_t buf_addr(input buf_ptr_t idx);
    return SC_BASE | bus_addr_t'(`RP_SC_ADDR_BUF) | (bus_addr_t'(idx) << 2); // word per entry
  endfunction

  ////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////

  task automatic check_data(input string name, input bus_data_t got, input bus_data_t exp);
    if (got !== exp)
    begin
      $display("ERR %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_code(input string name, input dac_code_t got, input dac_code_t exp);
    if (got !== exp)
    begin
      $display("ERR %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_led(input string name, input led_t got, input led_t exp);
    if (got !== exp)
    begin
      $display("ERR %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_err(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("ERR %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  ////////////////////////////////////////
  // bus master
  ////////////////////////////////////////

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge adc_clk);
  endtask

  task automatic bus_write(input bus_addr_t addr, input bus_data_t data, input logic exp_err);
    int n;
    @(posedge adc_clk);
    sys_addr_i  <= addr;
    sys_wdata_i <= data;
    sys_wen_i   <= 1'b1;
    @(posedge adc_clk);
    sys_wen_i <= 1'b0;                 // one cycle strobe
    n = 0;
    do
    begin
      @(negedge adc_clk);
      n++;
    end
    while (sys_ack_o !== 1'b1 && n < ACK_LIMIT);
    if (sys_ack_o !== 1'b1)
    begin
      $display("bus write to %h got no ack within %0d cycles", addr, ACK_LIMIT);
      errors++;
    end
    else
      check_err("sys_err_o", sys_err_o, exp_err);
  endtask

  task automatic bus_read(input bus_addr_t addr, input logic exp_err, output bus_data_t data);
    int n;
    @(posedge adc_clk);
    sys_addr_i <= addr;
    sys_ren_i  <= 1'b1;
    @(posedge adc_clk);
    sys_ren_i <= 1'b0;
    n = 0;
    do
    begin
      @(negedge adc_clk);
      n++;
    end
    while (sys_ack_o !== 1'b1 && n < ACK_LIMIT);
    data = sys_rdata_o;                // valid with ack
    if (sys_ack_o !== 1'b1)
    begin
      $display("bus read from %h got no ack within %0d cycles", addr, ACK_LIMIT);
      errors++;
    end
    else
      check_err("sys_err_o", sys_err_o, exp_err);
  endtask

  task automatic drive_pins(input adc_raw_t pins);
    @(posedge adc_clk);
    adc_dat_a_i <= pins;
    adc_dat_b_i <= pins;
  endtask

  // poll CTRL until done and fetch the trigger slot
  task automatic wait_done(output buf_ptr_t tptr);
    bus_data_t ctrl, tp;
    int        n;
    n    = 0;
    ctrl = '0;
    while (ctrl[1] !== 1'b1 && n < POLL_LIMIT)
    begin
      bus_read(sc_addr(`RP_SC_ADDR_CTRL), 1'b0, ctrl);
      n++;
    end
    if (ctrl[1] !== 1'b1)
    begin
      $display("scope capture did not finish after %0d polls", POLL_LIMIT);
      errors++;
    end
    else
      check_data("scope ctrl", ctrl, 32'h2); // done set and armed cleared
    bus_read(sc_addr(`RP_SC_ADDR_TRIGPTR), 1'b0, tp);
    tptr = buf_ptr_t'(tp);
  endtask

  // post-trigger entries wrap around the ring
  task automatic check_ring(input buf_ptr_t tptr, input smp_t exp);
    bus_data_t rd;
    buf_ptr_t  idx;
    for (int i = 0; i < `RP_POST_TRIG; i++)
    begin
      idx = buf_ptr_t'((int'(tptr) + i) % `RP_BUF_DEPTH);
      bus_read(buf_addr(idx), 1'b0, rd);
      check_data($sformatf("ring entry %0d", idx), rd, sext(exp));
    end
  endtask

  task automatic end_test(input string name, input int e0);
    tests_run++;
    if (errors == e0)
      $display("test %s passed", name);
    else
    begin
      tests_failed++;
      $display("test %s failed with %0d errors", name, errors - e0);
    end
  endtask

  ////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////

  task automatic test_reset();
    bus_data_t rd;
    int        e0;
    e0 = errors;
    @(negedge adc_clk);
    check_led("led_o", led_o, '0);
    check_code("dac_dat_a_o", dac_dat_a_o, to_code('0)); // level 0 -> midscale
    check_code("dac_dat_b_o", dac_dat_b_o, to_code('0));
    bus_read(hk_addr(`RP_HK_ADDR_ID), 1'b0, rd);
    check_data("hk id", rd, `RP_HK_ID);
    end_test("reset state", e0);
  endtask

  task automatic test_housekeeping();
    led_t      led;
    smp_t      lvl_a, lvl_b;
    bus_data_t rd;
    int        e0;
    e0      = errors;
    led     = led_t'($urandom);
    led_exp = led;
    lvl_a   = smp_t'($urandom);
    lvl_b   = smp_t'($urandom);
    bus_write(hk_addr(`RP_HK_ADDR_LED), bus_data_t'(led), 1'b0);
    bus_write(hk_addr(`RP_HK_ADDR_DAC_A), sext(lvl_a), 1'b0);
    bus_write(hk_addr(`RP_HK_ADDR_DAC_B), sext(lvl_b), 1'b0);
    bus_read(hk_addr(`RP_HK_ADDR_LED), 1'b0, rd);
    check_data("hk led", rd, bus_data_t'(led));
    bus_read(hk_addr(`RP_HK_ADDR_DAC_A), 1'b0, rd);
    check_data("hk dac a", rd, sext(lvl_a));
    bus_read(hk_addr(`RP_HK_ADDR_DAC_B), 1'b0, rd);
    check_data("hk dac b", rd, sext(lvl_b));
    wait_cycles(3);                    // level to pins takes 2
    @(negedge adc_clk);
    check_led("led_o", led_o, led);
    check_code("dac_dat_a_o", dac_dat_a_o, to_code(lvl_a));
    check_code("dac_dat_b_o", dac_dat_b_o, to_code(lvl_b));
    end_test("housekeeping", e0);
  endtask

  task automatic test_adc_scope();
    smp_t     neg, pos;
    buf_ptr_t tptr;
    int       e0;
    e0  = errors;
    neg = -14'sd100;
    pos = 14'sd1234;
    drive_pins(to_pin(neg));
    bus_write(sc_addr(`RP_SC_ADDR_THRESH), '0, 1'b0);
    wait_cycles(3);                    // let the negative value settle
    bus_write(sc_addr(`RP_SC_ADDR_CTRL), 32'h1, 1'b0);
    drive_pins(to_pin(pos));           // rising crossing of 0
    wait_done(tptr);
    check_ring(tptr, pos);
    end_test("adc conversion", e0);
  endtask

  task automatic test_loopback();
    smp_t      lo, hi;
    buf_ptr_t  tptr, prev;
    bus_data_t rd;
    int        e0;
    e0 = errors;
    lo = smp_t'(-1 - int'($urandom % 4000)); // below threshold 0
    hi = smp_t'(1 + int'($urandom % 4000));
    bus_write(hk_addr(`RP_HK_ADDR_LOOP), 32'h1, 1'b0);
    bus_write(hk_addr(`RP_HK_ADDR_DAC_A), sext(lo), 1'b0);
    wait_cycles(4);
    bus_write(sc_addr(`RP_SC_ADDR_CTRL), 32'h1, 1'b0);
    bus_write(hk_addr(`RP_HK_ADDR_DAC_A), sext(hi), 1'b0);
    wait_done(tptr);
    check_ring(tptr, hi);
    prev = buf_ptr_t'((int'(tptr) + `RP_BUF_DEPTH - 1) % `RP_BUF_DEPTH);
    bus_read(buf_addr(prev), 1'b0, rd);
    check_data("entry before trigger", rd, sext(lo));
    end_test("digital loopback", e0);
  endtask

  task automatic test_unused_region();
    bus_data_t rd;
    int        e0;
    e0 = errors;
    // led register offset in region 5
    bus_write(NU_BASE | bus_addr_t'(`RP_HK_ADDR_LED), ~bus_data_t'(led_exp), 1'b1);
    bus_read(NU_BASE | bus_addr_t'(`RP_HK_ADDR_LED), 1'b1, rd);
    check_data("unused rdata", rd, '0);
    bus_read(hk_addr(`RP_HK_ADDR_LED), 1'b0, rd);
    check_data("hk led after unused", rd, bus_data_t'(led_exp));
    check_led("led_o", led_o, led_exp);
    end_test("unused region", e0);
  endtask

  ////////////////////////////////////////
  // sequence and watchdog
  ////////////////////////////////////////

  initial
  begin
    void'($urandom(32'h9962));
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    rst_n_i     <= 1'b0;
    adc_dat_a_i <= '0;
    adc_dat_b_i <= '0;
    sys_addr_i  <= '0;
    sys_wdata_i <= '0;
    sys_wen_i   <= 1'b0;
    sys_ren_i   <= 1'b0;
    repeat (3) @(posedge adc_clk);
    rst_n_i <= 1'b1;
    test_reset();
    test_housekeeping();
    test_adc_scope();
    test_loopback();
    test_unused_region();
    $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

  initial
  begin
    cycles = 0;
    while (cycles < TIMEOUT_CYC)
    begin
      @(posedge adc_clk);
      cycles++;
    end
    $display("timeout, run stopped after %0d cycles", cycles);
    $display("=== FAIL ===");
    $finish;
  end

endmodule
